//--- Bender.yml
package:
  name: kdi

sources:
  # Packages ahead of the modules that import them
  - hdl/kdi_cfg_pkg.sv
  - hdl/kdi_types_pkg.sv
  - hdl/kdi_req_arbiter.sv
  - hdl/kdi_digest_core.sv
  - hdl/kdi_ctrl_fsm.sv
  - hdl/kdi_key_regs.sv
  - hdl/kdi_top.sv
  - target: simulation
    files:
      - bench/kdi_tb_sva.sv
      - bench/kdi_tb.sv

//--- bench/kdi_tb.sv
// Testbench for the key derivation unit with entropy responder and digest reference model
`timescale 1ns/100ps

module kdi_tb
  import kdi_cfg_pkg::*;
  import kdi_types_pkg::*;
();

  localparam int NumSramSlots = 2;
  localparam int NumReq       = NumFixedReq + NumSramSlots;
  localparam int NumRows      = 5;
  localparam int AckTimeout   = 400;

  // Requester mask, seed flag, seed base word, expected grant order (first grant low)
  typedef struct packed {
    logic [NumReq-1:0]      mask;
    logic                   seed_valid;
    logic [BlockWidth-1:0]  base;
    logic [NumReq-1:0][1:0] order;
  } stim_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic [NumReq-1:0]    req_i;
  logic [NumReq-1:0]    ack_o;
  logic [SeedWidth-1:0] flash_data_seed_i;
  logic [SeedWidth-1:0] flash_addr_seed_i;
  logic [KeyWidth-1:0]  sram_seed_i;
  logic                 seed_valid_i;
  logic                 edn_req_o;
  logic                 edn_ack_i;
  logic [EdnWidth-1:0]  edn_data_i;
  key_rsp_t             key_rsp_o;

  logic [31:0]                            rng_state = 32'h5729967c;
  // Entropy words in the order they were handed out
  logic [EdnWidth-1:0]                    edn_log [$];
  logic [MaxNonceWords-1:0][EdnWidth-1:0] exp_nonce;
  int                                     err_cnt;
  int                                     check_cnt;
  int                                     test_cnt;
  bit                                     timed_out;

  stim_t stim_table [NumRows] = '{
    // Flash data key
    '{mask: 4'b0001, seed_valid: 1'b1, base: 64'h3C5A_9E01_77D2_B4F8, order: 8'h00},
    // Flash address key, upper nonce word kept
    '{mask: 4'b0010, seed_valid: 1'b1, base: 64'hA18F_0C63_5E2B_D947, order: 8'h01},
    // First SRAM slot with entropy
    '{mask: 4'b0100, seed_valid: 1'b1, base: 64'h5D0E_B7A2_1946_C38F, order: 8'h02},
    // Invalid seed gated to zero
    '{mask: 4'b0001, seed_valid: 1'b0, base: 64'hF00D_2468_ACE1_3579, order: 8'h00},
    // Everyone at once, round robin after index 0
    '{mask: 4'b1111, seed_valid: 1'b1, base: 64'h8B3D_61F4_0A9C_E725,
      order: {2'd0, 2'd3, 2'd2, 2'd1}}
  };

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  kdi_top #(
    .NumSramSlots(NumSramSlots)
  ) dut (
    .clk_i, .rst_ni, .req_i, .ack_o, .flash_data_seed_i, .flash_addr_seed_i,
    .sram_seed_i, .seed_valid_i, .edn_req_o, .edn_ack_i, .edn_data_i, .key_rsp_o
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [63:0] rotl64(input logic [63:0] x, input int n);
    return (x << n) | (x >> (64 - n));
  endfunction

  // Xor in the block, rotate by 17, multiply mod 2^64
  function automatic logic [63:0] absorb_block(input logic [63:0] st, input logic [63:0] d);
    return rotl64(st ^ d, 17) * DigestMul;
  endfunction

  function automatic logic [63:0] finalize_block(input logic [63:0] st, input logic [63:0] iv);
    return rotl64(st, 31) ^ iv;
  endfunction

  // Four seed blocks spread from one base word
  function automatic logic [SeedWidth-1:0] expand_seed(input logic [63:0] base,
                                                       input logic [7:0] salt);
    logic [SeedWidth-1:0] s;
    for (int b = 0; b < 4; b++) begin
      s[64*b +: 64] = rotl64(base, 8 * b + salt) ^ {salt, 8'(b), 48'h5A5A_0000_C3C3};
    end
    return s;
  endfunction

  function automatic logic [EdnWidth-1:0] take_entropy_word();
    if (edn_log.size() == 0) begin
      err_cnt++;
      $display("Entropy log ran short of words for the reference model");
      return '0;
    end
    return edn_log.pop_front();
  endfunction

  task automatic compare_value(input string name, input logic [KeyWidth-1:0] exp,
                               input logic [KeyWidth-1:0] got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // Replays the derivation for requester idx from the logged entropy words
  task automatic check_response(input int idx, input logic sv);
    logic [SeedWidth-1:0]       seed;
    logic [BlockWidth-1:0]      iv;
    logic [BlockWidth-1:0]      st;
    logic [EdnWidth-1:0]        word;
    logic [1:0][BlockWidth-1:0] key;
    logic                       sram;
    int                         n_nonce;
    sram = (idx >= NumFixedReq);
    iv   = DigestIv[sram];
    if (idx == 0) begin
      seed = flash_data_seed_i;
    end else if (idx == 1) begin
      seed = flash_addr_seed_i;
    end else begin
      seed = {sram_seed_i, sram_seed_i};
    end
    if (!sv) begin
      seed = '0;
    end
    for (int h = 0; h < 2; h++) begin
      st = iv;
      st = absorb_block(st, seed[128*h +: 64]);
      st = absorb_block(st, seed[128*h+64 +: 64]);
      // SRAM halves also take two entropy words, parked in the nonce
      if (sram) begin
        for (int j = 0; j < 2; j++) begin
          word         = take_entropy_word();
          exp_nonce[j] = word;
          st           = absorb_block(st, word);
        end
      end
      key[h] = finalize_block(st, iv);
    end
    n_nonce = (idx == 1) ? 1 : 2;
    for (int j = 0; j < n_nonce; j++) begin
      exp_nonce[j] = take_entropy_word();
    end
    compare_value("key_rsp_o.key", key, key_rsp_o.key);
    compare_value("key_rsp_o.nonce", exp_nonce, key_rsp_o.nonce);
    compare_value("key_rsp_o.seed_valid", sv, key_rsp_o.seed_valid);
  endtask

  task automatic wait_for_ack(output int idx, output bit found);
    idx   = 0;
    found = 1'b0;
    for (int cyc = 0; cyc < AckTimeout && !found; cyc++) begin
      @(negedge clk_i);
      for (int k = NumReq - 1; k >= 0; k--) begin
        if (ack_o[k]) begin
          idx   = k;
          found = 1'b1;
        end
      end
    end
  endtask

  //////////////////////////////
  // Entropy responder
  //////////////////////////////

  // Acks 0 to 3 cycles after a request is seen
  initial begin : edn_responder
    int unsigned         delay;
    logic [EdnWidth-1:0] word;
    edn_ack_i  = 1'b0;
    edn_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (edn_req_o) begin
        delay = next_random() % 4;
        repeat (delay + 1) @(posedge clk_i);
        word = {next_random(), next_random()};
        edn_log.push_back(word);
        edn_data_i <= word;
        edn_ack_i  <= 1'b1;
        @(posedge clk_i);
        edn_ack_i <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : main_seq
    stim_t             row;
    int                idx;
    int                n_ack;
    int                row_err;
    bit                got_ack;
    logic [NumReq-1:0] pending;
    err_cnt           = 0;
    check_cnt         = 0;
    test_cnt          = 0;
    timed_out         = 1'b0;
    rst_ni            = 1'b0;
    req_i             = '0;
    flash_data_seed_i = '0;
    flash_addr_seed_i = '0;
    sram_seed_i       = '0;
    seed_valid_i      = 1'b0;
    exp_nonce         = NonceInit;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset values
    @(negedge clk_i);
    compare_value("key_rsp_o.key", KeyInit, key_rsp_o.key);
    compare_value("key_rsp_o.nonce", NonceInit, key_rsp_o.nonce);
    compare_value("key_rsp_o.seed_valid", '0, key_rsp_o.seed_valid);
    compare_value("edn_req_o", '0, edn_req_o);
    test_cnt++;
    $display("Test 0 reset values: %0d errors", err_cnt);

    for (int r = 0; r < NumRows && !timed_out; r++) begin
      row     = stim_table[r];
      row_err = err_cnt;
      n_ack   = 0;
      pending = row.mask;
      @(posedge clk_i);
      flash_data_seed_i <= expand_seed(row.base, 8'd0);
      flash_addr_seed_i <= expand_seed(row.base, 8'd1);
      sram_seed_i       <= KeyWidth'(expand_seed(row.base, 8'd2));
      seed_valid_i      <= row.seed_valid;
      req_i             <= row.mask;
      while (pending != '0 && n_ack < NumReq && !timed_out) begin
        wait_for_ack(idx, got_ack);
        if (!got_ack) begin
          err_cnt++;
          timed_out = 1'b1;
          $display("Timeout: no ack within %0d cycles in test %0d", AckTimeout, r + 1);
        end else begin
          if (!$onehot(ack_o)) begin
            err_cnt++;
            $display("More than one ack in the same cycle in test %0d", r + 1);
          end
          if (!pending[idx]) begin
            err_cnt++;
            $display("Ack to requester %0d, which was not waiting", idx);
          end
          compare_value("ack_o index", row.order[n_ack], idx);
          check_response(idx, row.seed_valid);
          pending[idx] = 1'b0;
          n_ack++;
          // Requester drops its req once the ack is seen
          @(posedge clk_i);
          req_i <= pending;
        end
      end
      if (edn_log.size() != 0) begin
        err_cnt++;
        $display("%0d entropy words were handed out but never used", edn_log.size());
        edn_log.delete();
      end
      test_cnt++;
      $display("Test %0d mask %b seed_valid %b: %0d errors", r + 1, row.mask,
               row.seed_valid, err_cnt - row_err);
    end

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- bench/kdi_tb_sva.sv
// Protocol assertions on key requests, acks and the entropy port of the key unit
`timescale 1ns/100ps

module kdi_tb_sva #(
  parameter int NumReq = 4
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic [NumReq-1:0] req_i,
  input logic [NumReq-1:0] ack_o,
  input logic              edn_req_o,
  input logic              edn_ack_i
);

  // Ack is a single-cycle pulse
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o != '0) |=> (ack_o == '0))
    else $error("ack_o held longer than one cycle");

  // Only a waiting requester gets an ack
  a_ack_to_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o & ~req_i) == '0)
    else $error("ack_o to an index without req_i");

  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(ack_o))
    else $error("more than one ack_o bit in a cycle");

  // Entropy request stays up until acked
  a_edn_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (edn_req_o && !edn_ack_i) |=> edn_req_o)
    else $error("edn_req_o dropped before edn_ack_i");

endmodule

bind kdi_top kdi_tb_sva #(
  .NumReq(NumReq)
) u_sva (
  .clk_i, .rst_ni, .req_i, .ack_o, .edn_req_o, .edn_ack_i
);

//--- hdl/kdi_cfg_pkg.sv
// Key derivation unit configuration: widths, counts, digest constants, reset values
package kdi_cfg_pkg;

  //////////////////////////////
  // Widths and counts
  //////////////////////////////

  // One digest block, also the size of each key half
  parameter int BlockWidth = 64;
  // Key is two finalized blocks
  parameter int KeyWidth   = 2 * BlockWidth;
  // Seed is four blocks, two per key half
  parameter int SeedWidth  = 4 * BlockWidth;
  // Entropy port word
  parameter int EdnWidth   = 64;

  // Nonce register depth in entropy words
  parameter int MaxNonceWords = 2;
  // Flash data and flash address requesters
  parameter int NumFixedReq   = 2;

  //////////////////////////////
  // Digest constants
  //////////////////////////////

  // IV table, entry 0 for flash keys and entry 1 for SRAM keys
  parameter logic [1:0][BlockWidth-1:0] DigestIv = {
    64'hBB67_AE85_84CA_A73B,
    64'h6A09_E667_F3BC_C908
  };

  // Odd multiplier used by every absorb step
  parameter logic [BlockWidth-1:0] DigestMul = 64'h9E37_79B9_7F4A_7C15;

  // Cycles from finalize acceptance to result
  parameter int DigestLatency = 2;

  //////////////////////////////
  // Output register reset values
  //////////////////////////////

  parameter logic [KeyWidth-1:0] KeyInit   = 128'hD3A1_5C2E_7B90_4F68_1E2D_3C4B_5A69_7887;
  parameter logic [KeyWidth-1:0] NonceInit = 128'h0F1E_2D3C_4B5A_6978_8796_A5B4_C3D2_E1F0;

endpackage

//--- hdl/kdi_ctrl_fsm.sv
// Key derivation sequencer for seed loading, entropy ingestion, finalization and nonce fetch
`timescale 1ns/100ps

module kdi_ctrl_fsm
  import kdi_cfg_pkg::*;
  import kdi_types_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Granted request
  input  logic                  valid_i,
  input  req_bundle_t           bundle_i,
  output logic                  done_o,
  // Digest engine
  output digest_req_t           dig_req_o,
  input  logic                  dig_ready_i,
  input  digest_rsp_t           dig_rsp_i,
  // Entropy port
  output logic                  edn_req_o,
  input  logic                  edn_ack_i,
  // Register controls
  output logic                  key_we_o,
  output logic                  key_half_o,
  output logic                  nonce_we_o,
  output logic                  nonce_idx_o,
  output logic                  seed_valid_we_o,
  output logic [1:0]            blk_idx_o,
  output logic                  use_entropy_o,
  input  logic [BlockWidth-1:0] blk_i
);

  typedef enum logic [3:0] {
    Idle,
    DigClr,
    DigLoad,
    FetchEntropy,
    DigEntropy,
    DigFin,
    DigWait,
    FetchNonce,
    Finish
  } state_e;

  state_e     state_d, state_q;
  // Seed block index, bit 1 is the key half
  logic [1:0] seed_cnt_d, seed_cnt_q;
  // Entropy / nonce word index
  logic       ent_cnt_d, ent_cnt_q;
  logic       edn_req_d, edn_req_q;
  logic       edn_ack;

  // Stray acks are dropped
  assign edn_ack = edn_ack_i && edn_req_q;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    seed_cnt_d      = seed_cnt_q;
    ent_cnt_d       = ent_cnt_q;
    // Pending request stays up until acked
    edn_req_d       = edn_req_q && !edn_ack_i;
    dig_req_o.valid = 1'b0;
    dig_req_o.cmd   = DigAbsorb;
    key_we_o        = 1'b0;
    nonce_we_o      = 1'b0;
    seed_valid_we_o = 1'b0;
    use_entropy_o   = 1'b0;
    done_o          = 1'b0;

    unique case (state_q)
      Idle: begin
        if (valid_i) begin
          state_d    = DigClr;
          seed_cnt_d = '0;
          ent_cnt_d  = 1'b0;
        end
      end
      // Revert the digest to the IV for this half
      DigClr: begin
        dig_req_o.valid = 1'b1;
        dig_req_o.cmd   = DigInit;
        if (dig_ready_i) begin
          state_d = DigLoad;
        end
      end
      // Two seed blocks per half
      DigLoad: begin
        dig_req_o.valid = 1'b1;
        if (dig_ready_i) begin
          if (seed_cnt_q[0]) begin
            state_d = bundle_i.ingest_entropy ? FetchEntropy : DigFin;
          end else begin
            seed_cnt_d = seed_cnt_q + 2'd1;
          end
        end
      end
      // Two entropy words, parked in the nonce register
      FetchEntropy: begin
        edn_req_d = 1'b1;
        if (edn_ack) begin
          nonce_we_o = 1'b1;
          ent_cnt_d  = ~ent_cnt_q;
          if (ent_cnt_q) begin
            edn_req_d = 1'b0;
            state_d   = DigEntropy;
          end
        end
      end
      DigEntropy: begin
        dig_req_o.valid = 1'b1;
        use_entropy_o   = 1'b1;
        if (dig_ready_i) begin
          ent_cnt_d = ~ent_cnt_q;
          if (ent_cnt_q) begin
            state_d = DigFin;
          end
        end
      end
      DigFin: begin
        dig_req_o.valid = 1'b1;
        dig_req_o.cmd   = DigFinal;
        if (dig_ready_i) begin
          state_d = DigWait;
        end
      end
      // Write the finalized half, then redo for the upper half
      DigWait: begin
        if (dig_rsp_i.valid) begin
          key_we_o = 1'b1;
          if (seed_cnt_q == 2'd1) begin
            seed_cnt_d = 2'd2;
            state_d    = DigClr;
          end else begin
            seed_cnt_d      = '0;
            seed_valid_we_o = 1'b1;
            state_d         = FetchNonce;
          end
        end
      end
      // Nonce words 0 up to nonce_last
      FetchNonce: begin
        edn_req_d = 1'b1;
        if (edn_ack) begin
          nonce_we_o = 1'b1;
          if (ent_cnt_q == bundle_i.nonce_last) begin
            ent_cnt_d = 1'b0;
            edn_req_d = 1'b0;
            state_d   = Finish;
          end else begin
            ent_cnt_d = ~ent_cnt_q;
          end
        end
      end
      Finish: begin
        done_o  = 1'b1;
        state_d = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  //////////////////////////////
  // Outputs and registers
  //////////////////////////////

  assign dig_req_o.sel  = bundle_i.digest_sel;
  assign dig_req_o.data = blk_i;
  assign key_half_o     = seed_cnt_q[1];
  assign nonce_idx_o    = ent_cnt_q;
  // Entropy phase reuses bit 0 as the nonce word select
  assign blk_idx_o      = use_entropy_o ? {1'b0, ent_cnt_q} : seed_cnt_q;
  assign edn_req_o      = edn_req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q    <= Idle;
      seed_cnt_q <= '0;
      ent_cnt_q  <= 1'b0;
      edn_req_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      seed_cnt_q <= seed_cnt_d;
      ent_cnt_q  <= ent_cnt_d;
      edn_req_q  <= edn_req_d;
    end
  end

endmodule

//--- hdl/kdi_digest_core.sv
// 64-bit block digest engine with init, absorb and finalize commands
`timescale 1ns/100ps

module kdi_digest_core
  import kdi_cfg_pkg::*;
  import kdi_types_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  digest_req_t req_i,
  output logic        ready_o,
  output digest_rsp_t rsp_o
);

  localparam int CntW = $clog2(DigestLatency + 1);

  // Rotate left by a fixed amount
  function automatic logic [BlockWidth-1:0] rotl(input logic [BlockWidth-1:0] x,
                                                 input int unsigned n);
    return (x << n) | (x >> (BlockWidth - n));
  endfunction

  logic [BlockWidth-1:0] state_q;
  logic [BlockWidth-1:0] fin_q;
  logic [CntW-1:0]       cnt_q;
  logic                  accept;
  logic [BlockWidth-1:0] absorb_val;
  logic [BlockWidth-1:0] final_val;

  //////////////////////////////
  // Mixing
  //////////////////////////////

  // Absorb: rotate the xor, then multiply mod 2^64
  assign absorb_val = rotl(state_q ^ req_i.data, 17) * DigestMul;
  // Finalize: rotate state and fold the IV back in
  assign final_val  = rotl(state_q, 31) ^ DigestIv[req_i.sel];

  // Busy while a finalize is in flight
  assign ready_o = (cnt_q == '0);
  assign accept  = req_i.valid && ready_o;

  always_ff @(posedge clk_i) begin : p_state
    if (accept) begin
      unique case (req_i.cmd)
        DigInit:   state_q <= DigestIv[req_i.sel];
        DigAbsorb: state_q <= absorb_val;
        DigFinal:  fin_q   <= final_val;
        default:   state_q <= state_q;
      endcase
    end
  end

  //////////////////////////////
  // Latency counter
  //////////////////////////////

  // Loaded on finalize, counts down to the result cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (accept && (req_i.cmd == DigFinal)) begin
      cnt_q <= CntW'(DigestLatency);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Result pulses on the last count, DigestLatency cycles after acceptance
  assign rsp_o.valid = (cnt_q == CntW'(1));
  assign rsp_o.data  = fin_q;

endmodule

//--- hdl/kdi_key_regs.sv
// Key, nonce and seed-valid output registers with the digest input block selector
`timescale 1ns/100ps

module kdi_key_regs
  import kdi_cfg_pkg::*;
  import kdi_types_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Controls from the sequencer
  input  logic                  key_we_i,
  input  logic                  key_half_i,
  input  logic                  nonce_we_i,
  input  logic                  nonce_idx_i,
  input  logic                  seed_valid_we_i,
  input  logic [1:0]            blk_idx_i,
  input  logic                  use_entropy_i,
  // Data sources
  input  digest_rsp_t           dig_rsp_i,
  input  logic [EdnWidth-1:0]   edn_data_i,
  input  req_bundle_t           bundle_i,
  // Digest input block and result
  output logic [BlockWidth-1:0] blk_o,
  output key_rsp_t              key_rsp_o
);

  logic [1:0][BlockWidth-1:0]             key_q;
  logic [MaxNonceWords-1:0][EdnWidth-1:0] nonce_q;
  logic                                   seed_valid_q;

  //////////////////////////////
  // Output registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_out
    if (!rst_ni) begin
      key_q        <= KeyInit;
      nonce_q      <= NonceInit;
      seed_valid_q <= 1'b0;
    end else begin
      // Half 0 lands in the low block
      if (key_we_i) begin
        key_q[key_half_i] <= dig_rsp_i.data;
      end
      // Entropy and nonce words share this register
      if (nonce_we_i) begin
        nonce_q[nonce_idx_i] <= edn_data_i;
      end
      if (seed_valid_we_i) begin
        seed_valid_q <= bundle_i.seed_valid;
      end
    end
  end

  //////////////////////////////
  // Digest input select
  //////////////////////////////

  // Invalid seeds are fed as zero blocks
  always_comb begin : p_blk
    if (use_entropy_i) begin
      blk_o = nonce_q[blk_idx_i[0]];
    end else if (bundle_i.seed_valid) begin
      blk_o = bundle_i.seed[blk_idx_i];
    end else begin
      blk_o = '0;
    end
  end

  assign key_rsp_o.key        = key_q;
  assign key_rsp_o.nonce      = nonce_q;
  assign key_rsp_o.seed_valid = seed_valid_q;

endmodule

//--- hdl/kdi_req_arbiter.sv
// Round-robin arbiter that locks one key request until the sequencer reports completion
`timescale 1ns/100ps

module kdi_req_arbiter
  import kdi_cfg_pkg::*;
  import kdi_types_pkg::*;
#(
  parameter int NumSramSlots = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [NumFixedReq+NumSramSlots-1:0] req_i,
  input  req_bundle_t                         bundle_i [NumFixedReq+NumSramSlots],
  input  logic                                done_i,
  output logic                                valid_o,
  output req_bundle_t                         bundle_o,
  output logic [NumFixedReq+NumSramSlots-1:0] ack_o
);

  localparam int NumReq = NumFixedReq + NumSramSlots;
  localparam int IdxW   = $clog2(NumReq);

  // Locked grant and the index granted before it
  logic            locked_q;
  logic [IdxW-1:0] idx_q;
  logic [IdxW-1:0] last_q;

  logic            pick_found;
  logic [IdxW-1:0] pick_idx;

  // Search starts one past the last grant and wraps
  always_comb begin : p_pick
    int unsigned cand;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int unsigned i = 1; i <= NumReq; i++) begin
      cand = (int'(last_q) + i) % NumReq;
      if (!pick_found && req_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = IdxW'(cand);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lock
    if (!rst_ni) begin
      locked_q <= 1'b0;
      idx_q    <= '0;
      // First search then begins at index 0
      last_q   <= IdxW'(NumReq - 1);
    end else if (locked_q) begin
      if (done_i) begin
        locked_q <= 1'b0;
        last_q   <= idx_q;
      end
    end else if (pick_found) begin
      locked_q <= 1'b1;
      idx_q    <= pick_idx;
    end
  end

  // Ack goes back to the locked index in the done cycle only
  always_comb begin : p_ack
    ack_o = '0;
    if (locked_q) begin
      ack_o[idx_q] = done_i;
    end
  end

  assign valid_o  = locked_q;
  assign bundle_o = bundle_i[idx_q];

endmodule

//--- hdl/kdi_top.sv
// Key derivation unit top level: request bundles, arbitration, sequencing and digest
`timescale 1ns/100ps

module kdi_top
  import kdi_cfg_pkg::*;
  import kdi_types_pkg::*;
#(
  parameter int NumSramSlots = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Requesters, 0 flash data, 1 flash address, then SRAM slots
  input  logic [NumFixedReq+NumSramSlots-1:0] req_i,
  output logic [NumFixedReq+NumSramSlots-1:0] ack_o,
  // Seeds from OTP
  input  logic [SeedWidth-1:0]                flash_data_seed_i,
  input  logic [SeedWidth-1:0]                flash_addr_seed_i,
  input  logic [KeyWidth-1:0]                 sram_seed_i,
  input  logic                                seed_valid_i,
  // Entropy port
  output logic                                edn_req_o,
  input  logic                                edn_ack_i,
  input  logic [EdnWidth-1:0]                 edn_data_i,
  // Shared result
  output key_rsp_t                            key_rsp_o
);

  localparam int NumReq = NumFixedReq + NumSramSlots;

  req_bundle_t           bundles [NumReq];
  req_bundle_t           bundle;
  logic                  req_valid;
  logic                  done;
  digest_req_t           dig_req;
  digest_rsp_t           dig_rsp;
  logic                  dig_ready;
  logic                  key_we, key_half, nonce_we, nonce_idx, seed_valid_we;
  logic [1:0]            blk_idx;
  logic                  use_entropy;
  logic [BlockWidth-1:0] blk;

  //////////////////////////////
  // Request bundles
  //////////////////////////////

  // Flash data key, two nonce words
  assign bundles[0] = '{ingest_entropy: 1'b0, digest_sel: FlashSel, nonce_last: 1'b1,
                        seed_valid: seed_valid_i, seed: flash_data_seed_i};
  // Flash address key, one nonce word
  assign bundles[1] = '{ingest_entropy: 1'b0, digest_sel: FlashSel, nonce_last: 1'b0,
                        seed_valid: seed_valid_i, seed: flash_addr_seed_i};

  // SRAM slots reuse one seed for both halves
  for (genvar k = NumFixedReq; k < NumReq; k++) begin : gen_sram_bundle
    assign bundles[k] = '{ingest_entropy: 1'b1, digest_sel: SramSel, nonce_last: 1'b1,
                          seed_valid: seed_valid_i, seed: {sram_seed_i, sram_seed_i}};
  end

  kdi_req_arbiter #(
    .NumSramSlots(NumSramSlots)
  ) u_arb (
    .clk_i, .rst_ni, .req_i, .bundle_i(bundles), .done_i(done),
    .valid_o(req_valid), .bundle_o(bundle), .ack_o
  );

  kdi_ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .valid_i(req_valid), .bundle_i(bundle), .done_o(done),
    .dig_req_o(dig_req), .dig_ready_i(dig_ready), .dig_rsp_i(dig_rsp),
    .edn_req_o, .edn_ack_i, .key_we_o(key_we), .key_half_o(key_half),
    .nonce_we_o(nonce_we), .nonce_idx_o(nonce_idx), .seed_valid_we_o(seed_valid_we),
    .blk_idx_o(blk_idx), .use_entropy_o(use_entropy), .blk_i(blk)
  );

  kdi_key_regs u_regs (
    .clk_i, .rst_ni, .key_we_i(key_we), .key_half_i(key_half), .nonce_we_i(nonce_we),
    .nonce_idx_i(nonce_idx), .seed_valid_we_i(seed_valid_we), .blk_idx_i(blk_idx),
    .use_entropy_i(use_entropy), .dig_rsp_i(dig_rsp), .edn_data_i, .bundle_i(bundle),
    .blk_o(blk), .key_rsp_o
  );

  kdi_digest_core u_digest (
    .clk_i, .rst_ni, .req_i(dig_req), .ready_o(dig_ready), .rsp_o(dig_rsp)
  );

endmodule

//--- hdl/kdi_types_pkg.sv
// Key derivation unit types shared between arbiter, sequencer, digest core and registers
package kdi_types_pkg;

  import kdi_cfg_pkg::*;

  // IV select, doubles as the index into DigestIv
  typedef enum logic {
    FlashSel = 1'b0,
    SramSel  = 1'b1
  } digest_sel_e;

  // Digest engine commands
  typedef enum logic [1:0] {
    DigInit   = 2'd0,
    DigAbsorb = 2'd1,
    DigFinal  = 2'd2
  } digest_cmd_e;

  // Per-requester derivation recipe
  typedef struct packed {
    logic                             ingest_entropy;
    digest_sel_e                      digest_sel;
    // Index of the last nonce word to fetch
    logic                             nonce_last;
    logic                             seed_valid;
    logic [3:0][BlockWidth-1:0]       seed;
  } req_bundle_t;

  // Result seen by every requester
  typedef struct packed {
    logic [KeyWidth-1:0]              key;
    logic [MaxNonceWords*EdnWidth-1:0] nonce;
    logic                             seed_valid;
  } key_rsp_t;

  // Command into the digest engine
  typedef struct packed {
    logic                             valid;
    digest_cmd_e                      cmd;
    digest_sel_e                      sel;
    logic [BlockWidth-1:0]            data;
  } digest_req_t;

  // Finalized block out of the digest engine
  typedef struct packed {
    logic                             valid;
    logic [BlockWidth-1:0]            data;
  } digest_rsp_t;

endpackage

//--- project.f
hdl/kdi_cfg_pkg.sv
hdl/kdi_types_pkg.sv
hdl/kdi_req_arbiter.sv
hdl/kdi_digest_core.sv
hdl/kdi_ctrl_fsm.sv
hdl/kdi_key_regs.sv
hdl/kdi_top.sv
bench/kdi_tb_sva.sv
bench/kdi_tb.sv
